// File: rtl/clint_config.svh
// CLINT build configuration
//   hart count, data, tag and offset widths
//   register offsets of msip, mtimecmp and mtime
//   read-kind codes shared by decoder and response stage

`ifndef CLINT_CONFIG_SVH
`define CLINT_CONFIG_SVH

`define CLINT_NUM_HARTS     4
`define CLINT_HART_W        2        // bits of a hart index
`define CLINT_XLEN          64
`define CLINT_BE_W          (`CLINT_XLEN / 8)
`define CLINT_TAG_W         4
`define CLINT_OFF_W         16

`define CLINT_MSIP_BASE     16'h0000 // 4 bytes per hart
`define CLINT_MTIMECMP_BASE 16'h4000 // 8 bytes per hart
`define CLINT_MTIME_OFF     16'hbff8

`define CLINT_KIND_NONE     2'd0
`define CLINT_KIND_MSIP     2'd1
`define CLINT_KIND_MTIMECMP 2'd2
`define CLINT_KIND_MTIME    2'd3

`endif

// File: rtl/clint_pkg.sv
// CLINT shared types
//   register word, byte enables, request tag
//   register offset, hart index, read kind

`default_nettype none

`include "clint_config.svh"

package clint_pkg;

  // --------------------------------------------------------------------------
  // data path
  // --------------------------------------------------------------------------

  // one register or data word
  typedef logic [`CLINT_XLEN-1:0]  xlen_t;

  typedef logic [`CLINT_BE_W-1:0]  byte_en_t;    // one enable per byte of xlen_t

  // --------------------------------------------------------------------------
  // request fields
  // --------------------------------------------------------------------------

  typedef logic [`CLINT_TAG_W-1:0] tag_t;        // echoed on the response

  typedef logic [`CLINT_OFF_W-1:0] reg_off_t;    // register-relative offset

  // decoder results
  typedef logic [`CLINT_HART_W-1:0] hart_id_t;

  typedef logic [1:0]               reg_kind_t;  // coded by CLINT_KIND_*

endpackage

`default_nettype wire

// File: rtl/clint_req_decode.sv
// CLINT request decoder
//   request acceptance
//   offset match against msip, mtimecmp and mtime
//   per-register write strobes, read kind and hart index

`default_nettype none

`include "clint_config.svh"

module clint_req_decode
  import clint_pkg::*;
(
  input  logic                        i_req_valid,
  input  logic                        i_req_ready,
  input  logic                        i_req_write,
  input  reg_off_t                    i_req_off,
  input  xlen_t                       i_req_data,
  input  byte_en_t                    i_req_byte_en,

  output logic                        o_accept,
  output logic                        o_mtime_we,
  output logic [`CLINT_NUM_HARTS-1:0] o_msip_we,
  output logic [`CLINT_NUM_HARTS-1:0] o_mtimecmp_we,
  output xlen_t                       o_wdata,
  output byte_en_t                    o_wbe,
  output reg_kind_t                   o_rd_kind,
  output hart_id_t                    o_rd_hart
);

  reg_off_t  w_msip_rel;
  reg_off_t  w_mtimecmp_rel;
  logic      w_msip_hit;
  logic      w_mtimecmp_hit;
  logic      w_mtime_hit;
  reg_kind_t w_kind;
  hart_id_t  w_hart;
  logic      w_wr_acc;

  assign o_accept = i_req_valid & i_req_ready;
  assign w_wr_acc = o_accept & i_req_write;

  // --------------------------------------------------------------------------
  // offset match
  // --------------------------------------------------------------------------

  assign w_msip_rel     = i_req_off - `CLINT_MSIP_BASE;
  assign w_mtimecmp_rel = i_req_off - `CLINT_MTIMECMP_BASE;

  // below base wraps to a large value and fails the range check
  assign w_msip_hit     = (w_msip_rel < reg_off_t'(4 * `CLINT_NUM_HARTS)) &&
                          (w_msip_rel[1:0] == 2'b00);
  assign w_mtimecmp_hit = (w_mtimecmp_rel < reg_off_t'(8 * `CLINT_NUM_HARTS)) &&
                          (w_mtimecmp_rel[2:0] == 3'b000);
  assign w_mtime_hit    = (i_req_off == `CLINT_MTIME_OFF);

  always_comb begin
    w_kind = `CLINT_KIND_NONE;
    w_hart = '0;
    if (w_msip_hit) begin
      w_kind = `CLINT_KIND_MSIP;
      w_hart = w_msip_rel[2 +: `CLINT_HART_W];      // 4-byte stride
    end else if (w_mtimecmp_hit) begin
      w_kind = `CLINT_KIND_MTIMECMP;
      w_hart = w_mtimecmp_rel[3 +: `CLINT_HART_W];  // 8-byte stride
    end else if (w_mtime_hit) begin
      w_kind = `CLINT_KIND_MTIME;
    end
  end

  assign o_rd_kind = w_kind;
  assign o_rd_hart = w_hart;

  // --------------------------------------------------------------------------
  // write strobes, at most one per accepted write
  // --------------------------------------------------------------------------

  always_comb begin
    o_msip_we     = '0;
    o_mtimecmp_we = '0;
    if (w_wr_acc && (w_kind == `CLINT_KIND_MSIP)) begin
      o_msip_we[w_hart] = 1'b1;
    end
    if (w_wr_acc && (w_kind == `CLINT_KIND_MTIMECMP)) begin
      o_mtimecmp_we[w_hart] = 1'b1;
    end
  end

  assign o_mtime_we = w_wr_acc && (w_kind == `CLINT_KIND_MTIME);

  assign o_wdata = i_req_data;     // register-relative, no lane steering
  assign o_wbe   = i_req_byte_en;

endmodule

`default_nettype wire

// File: rtl/clint_mtime.sv
// CLINT shared time base
//   free-running 64-bit mtime counter, one count per clock
//   byte-enabled writes laid over the incremented value

`default_nettype none

`include "clint_config.svh"

module clint_mtime
  import clint_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_reset_n,

  input  logic     i_we,
  input  xlen_t    i_wdata,
  input  byte_en_t i_wbe,

  output xlen_t    o_mtime
);

  xlen_t r_mtime;
  xlen_t w_inc;
  xlen_t w_next;

  assign w_inc = r_mtime + 1'b1;   // wraps at 2^64

  // enabled bytes come from the write, the rest keep counting
  always_comb begin
    w_next = w_inc;
    if (i_we) begin
      for (int b_idx = 0; b_idx < `CLINT_BE_W; b_idx++) begin
        if (i_wbe[b_idx]) begin
          w_next[b_idx*8 +: 8] = i_wdata[b_idx*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_mtime <= '0;
    end else begin
      r_mtime <= w_next;
    end
  end

  assign o_mtime = r_mtime;

endmodule

`default_nettype wire

// File: rtl/clint_hart_irq.sv
// CLINT per-hart interrupt block
//   msip bit, drives the software interrupt
//   mtimecmp register with byte-enabled writes
//   timer interrupt from mtime >= mtimecmp

`default_nettype none

`include "clint_config.svh"

module clint_hart_irq
  import clint_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_reset_n,

  input  logic     i_msip_we,
  input  logic     i_mtimecmp_we,
  input  xlen_t    i_wdata,
  input  byte_en_t i_wbe,
  input  xlen_t    i_mtime,

  output logic     o_msip,
  output xlen_t    o_mtimecmp,
  output logic     o_mtip
);

  logic  r_msip;
  xlen_t r_mtimecmp;
  xlen_t w_mtimecmp_next;

  // --------------------------------------------------------------------------
  // software interrupt
  // --------------------------------------------------------------------------

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_msip <= 1'b0;
    end else if (i_msip_we && i_wbe[0]) begin
      r_msip <= i_wdata[0];          // only bit 0 is implemented
    end
  end

  // --------------------------------------------------------------------------
  // timer compare
  // --------------------------------------------------------------------------

  always_comb begin
    w_mtimecmp_next = r_mtimecmp;
    for (int b_idx = 0; b_idx < `CLINT_BE_W; b_idx++) begin
      if (i_wbe[b_idx]) begin
        w_mtimecmp_next[b_idx*8 +: 8] = i_wdata[b_idx*8 +: 8];
      end
    end
  end

  // all ones keeps mtip low out of reset
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_mtimecmp <= '1;
    end else if (i_mtimecmp_we) begin
      r_mtimecmp <= w_mtimecmp_next;
    end
  end

  assign o_msip     = r_msip;
  assign o_mtimecmp = r_mtimecmp;
  assign o_mtip     = (i_mtime >= r_mtimecmp);   // unsigned

endmodule

`default_nettype wire

// File: rtl/clint_resp_mux.sv
// CLINT response stage
//   read data select by kind and hart
//   one-entry response register, held under back-pressure
//   request ready from occupancy and response ready

`default_nettype none

`include "clint_config.svh"

module clint_resp_mux
  import clint_pkg::*;
(
  input  logic                        i_clk,
  input  logic                        i_reset_n,

  input  logic                        i_accept,
  input  logic                        i_write,
  input  tag_t                        i_tag,
  input  reg_kind_t                   i_rd_kind,
  input  hart_id_t                    i_rd_hart,

  input  xlen_t                       i_mtime,
  input  logic [`CLINT_NUM_HARTS-1:0] i_msip,
  input  xlen_t                       i_mtimecmp [`CLINT_NUM_HARTS],

  input  logic                        i_resp_ready,
  output logic                        o_req_ready,
  output logic                        o_resp_valid,
  output tag_t                        o_resp_tag,
  output xlen_t                       o_resp_data
);

  logic  r_valid;
  tag_t  r_tag;
  xlen_t r_data;
  xlen_t w_rd_data;

  // --------------------------------------------------------------------------
  // read select, values before this edge's update
  // --------------------------------------------------------------------------

  always_comb begin
    w_rd_data = '0;                  // writes and unmapped offsets
    if (!i_write) begin
      case (i_rd_kind)
        `CLINT_KIND_MSIP:     w_rd_data = xlen_t'(i_msip[i_rd_hart]);
        `CLINT_KIND_MTIMECMP: w_rd_data = i_mtimecmp[i_rd_hart];
        `CLINT_KIND_MTIME:    w_rd_data = i_mtime;
        default:              w_rd_data = '0;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // response entry
  // --------------------------------------------------------------------------

  // free now, or draining this cycle
  assign o_req_ready = !r_valid || i_resp_ready;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else if (i_accept) begin
      r_valid <= 1'b1;               // refill on the same edge as a transfer
    end else if (i_resp_ready) begin
      r_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_accept) begin
      r_tag  <= i_tag;
      r_data <= w_rd_data;
    end
  end

  assign o_resp_valid = r_valid;
  assign o_resp_tag   = r_tag;
  assign o_resp_data  = r_data;

endmodule

`default_nettype wire

// File: rtl/clint.sv
// CLINT top level
//   request decoder
//   shared mtime counter
//   one interrupt block per hart
//   response stage

`default_nettype none

`include "clint_config.svh"

module clint
  import clint_pkg::*;
(
  input  logic                        i_clk,
  input  logic                        i_reset_n,

  input  logic                        i_req_valid,
  input  logic                        i_req_write,
  input  reg_off_t                    i_req_off,
  input  tag_t                        i_req_tag,
  input  xlen_t                       i_req_data,
  input  byte_en_t                    i_req_byte_en,
  output logic                        o_req_ready,

  output logic                        o_resp_valid,
  output tag_t                        o_resp_tag,
  output xlen_t                       o_resp_data,
  input  logic                        i_resp_ready,

  output logic [`CLINT_NUM_HARTS-1:0] o_msip,
  output logic [`CLINT_NUM_HARTS-1:0] o_mtip
);

  logic                        w_accept;
  logic                        w_mtime_we;
  logic [`CLINT_NUM_HARTS-1:0] w_msip_we;
  logic [`CLINT_NUM_HARTS-1:0] w_mtimecmp_we;
  xlen_t                       w_wdata;
  byte_en_t                    w_wbe;
  reg_kind_t                   w_rd_kind;
  hart_id_t                    w_rd_hart;
  xlen_t                       w_mtime;
  xlen_t                       w_mtimecmp [`CLINT_NUM_HARTS];

  clint_req_decode u_decode (
    .i_req_valid   (i_req_valid),
    .i_req_ready   (o_req_ready),
    .i_req_write   (i_req_write),
    .i_req_off     (i_req_off),
    .i_req_data    (i_req_data),
    .i_req_byte_en (i_req_byte_en),
    .o_accept      (w_accept),
    .o_mtime_we    (w_mtime_we),
    .o_msip_we     (w_msip_we),
    .o_mtimecmp_we (w_mtimecmp_we),
    .o_wdata       (w_wdata),
    .o_wbe         (w_wbe),
    .o_rd_kind     (w_rd_kind),
    .o_rd_hart     (w_rd_hart)
  );

  clint_mtime u_mtime (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_we      (w_mtime_we),
    .i_wdata   (w_wdata),
    .i_wbe     (w_wbe),
    .o_mtime   (w_mtime)
  );

  // --------------------------------------------------------------------------
  // per-hart interrupt blocks
  // --------------------------------------------------------------------------

  generate
    for (genvar h_idx = 0; h_idx < `CLINT_NUM_HARTS; h_idx++) begin : g_hart
      clint_hart_irq u_hart (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_msip_we     (w_msip_we[h_idx]),
        .i_mtimecmp_we (w_mtimecmp_we[h_idx]),
        .i_wdata       (w_wdata),
        .i_wbe         (w_wbe),
        .i_mtime       (w_mtime),
        .o_msip        (o_msip[h_idx]),
        .o_mtimecmp    (w_mtimecmp[h_idx]),
        .o_mtip        (o_mtip[h_idx])
      );
    end
  endgenerate

  clint_resp_mux u_resp (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_accept     (w_accept),
    .i_write      (i_req_write),
    .i_tag        (i_req_tag),
    .i_rd_kind    (w_rd_kind),
    .i_rd_hart    (w_rd_hart),
    .i_mtime      (w_mtime),
    .i_msip       (o_msip),
    .i_mtimecmp   (w_mtimecmp),
    .i_resp_ready (i_resp_ready),
    .o_req_ready  (o_req_ready),
    .o_resp_valid (o_resp_valid),
    .o_resp_tag   (o_resp_tag),
    .o_resp_data  (o_resp_data)
  );

endmodule

`default_nettype wire

// File: sim/tb_clint.sv
// CLINT testbench
//   clock, reset, request and response-ready drivers
//   reference model of msip, mtimecmp and mtime
//   response scoreboard, interrupt and handshake assertions
//   cycle-count timeout

`default_nettype none

`include "clint_config.svh"

module tb_clint
  import clint_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_HARTS  = `CLINT_NUM_HARTS;
  localparam int MAX_CYCLES = 2000;

  logic                 i_clk;
  logic                 i_reset_n;
  logic                 i_req_valid;
  logic                 i_req_write;
  reg_off_t             i_req_off;
  tag_t                 i_req_tag;
  xlen_t                i_req_data;
  byte_en_t             i_req_byte_en;
  logic                 o_req_ready;
  logic                 o_resp_valid;
  tag_t                 o_resp_tag;
  xlen_t                o_resp_data;
  logic                 i_resp_ready;
  logic [NUM_HARTS-1:0] o_msip;
  logic [NUM_HARTS-1:0] o_mtip;

  xlen_t                m_mtime;            // model state of the current cycle
  xlen_t                m_cmp [NUM_HARTS];
  logic [NUM_HARTS-1:0] m_msip;
  tag_t                 exp_tag_q [$];
  xlen_t                exp_data_q [$];
  logic                 hold_prev;
  tag_t                 prev_tag;
  xlen_t                prev_data;
  tag_t                 next_tag;
  int                   resp_mode;          // 0 ready, 1 random, 2 stalled
  int                   cycle_count;
  integer               seed;

  clint uut (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_req_valid   (i_req_valid),
    .i_req_write   (i_req_write),
    .i_req_off     (i_req_off),
    .i_req_tag     (i_req_tag),
    .i_req_data    (i_req_data),
    .i_req_byte_en (i_req_byte_en),
    .o_req_ready   (o_req_ready),
    .o_resp_valid  (o_resp_valid),
    .o_resp_tag    (o_resp_tag),
    .o_resp_data   (o_resp_data),
    .i_resp_ready  (i_resp_ready),
    .o_msip        (o_msip),
    .o_mtip        (o_mtip)
  );

  always #50 i_clk = ~i_clk;

  // ----------------------------------------------------------------------------
  // failure reporting
  // ----------------------------------------------------------------------------

  task automatic stop_on_failure();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input xlen_t exp_val, input xlen_t act_val);
    $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
    stop_on_failure();
  endtask

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == MAX_CYCLES) begin
      $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
      stop_on_failure();
    end
  end

  // ----------------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------------

  function automatic xlen_t merge_bytes(input xlen_t old_val, input xlen_t new_val,
                                        input byte_en_t be);
    xlen_t res;
    res = old_val;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) res[b*8 +: 8] = new_val[b*8 +: 8];
    end
    return res;
  endfunction

  function automatic reg_off_t msip_off(input int h);
    return reg_off_t'(`CLINT_MSIP_BASE + 4 * h);
  endfunction

  function automatic reg_off_t mtimecmp_off(input int h);
    return reg_off_t'(`CLINT_MTIMECMP_BASE + 8 * h);
  endfunction

  // register kind and hart of an offset or kind none when unmapped or misaligned
  function automatic void decode_offset(input reg_off_t off, output reg_kind_t kind,
                                        output hart_id_t hart);
    kind = `CLINT_KIND_NONE;
    hart = '0;
    for (int h = 0; h < NUM_HARTS; h++) begin
      if (off == msip_off(h)) begin
        kind = `CLINT_KIND_MSIP;
        hart = hart_id_t'(h);
      end
      if (off == mtimecmp_off(h)) begin
        kind = `CLINT_KIND_MTIMECMP;
        hart = hart_id_t'(h);
      end
    end
    if (off == `CLINT_MTIME_OFF) kind = `CLINT_KIND_MTIME;
  endfunction

  task automatic model_reset();
    m_mtime   = '0;
    m_msip    = '0;
    hold_prev = 1'b0;
    for (int h = 0; h < NUM_HARTS; h++) m_cmp[h] = '1;
    exp_tag_q.delete();
    exp_data_q.delete();
  endtask

  task automatic check_outputs();
    for (int h = 0; h < NUM_HARTS; h++) begin
      assert (o_msip[h] == m_msip[h])
        else report_mismatch($sformatf("o_msip[%0d]", h), xlen_t'(m_msip[h]), xlen_t'(o_msip[h]));
      assert (o_mtip[h] == (m_mtime >= m_cmp[h]))
        else report_mismatch($sformatf("o_mtip[%0d]", h), xlen_t'(m_mtime >= m_cmp[h]),
                             xlen_t'(o_mtip[h]));
    end
  endtask

  task automatic check_response();
    tag_t  e_tag;
    xlen_t e_data;
    if (hold_prev) begin            // entry must not move after a stalled cycle
      assert (o_resp_valid) else report_mismatch("o_resp_valid", 64'd1, xlen_t'(o_resp_valid));
      assert (o_resp_tag == prev_tag)
        else report_mismatch("o_resp_tag", xlen_t'(prev_tag), xlen_t'(o_resp_tag));
      assert (o_resp_data == prev_data) else report_mismatch("o_resp_data", prev_data, o_resp_data);
    end
    hold_prev = o_resp_valid && !i_resp_ready;
    prev_tag  = o_resp_tag;
    prev_data = o_resp_data;
    if (o_resp_valid && i_resp_ready) begin
      if (exp_tag_q.size() == 0) begin
        $display("response transferred with no request outstanding at %0t", $time);
        stop_on_failure();
      end else begin
        e_tag  = exp_tag_q.pop_front();
        e_data = exp_data_q.pop_front();
        assert (o_resp_tag == e_tag)
          else report_mismatch("o_resp_tag", xlen_t'(e_tag), xlen_t'(o_resp_tag));
        assert (o_resp_data == e_data) else report_mismatch("o_resp_data", e_data, o_resp_data);
      end
    end
  endtask

  // state after the coming edge
  task automatic update_model();
    reg_kind_t kind;
    hart_id_t  hart;
    xlen_t     rd_val;
    xlen_t     next_mtime;
    decode_offset(i_req_off, kind, hart);
    next_mtime = m_mtime + 64'd1;
    if (i_req_valid && o_req_ready) begin
      rd_val = '0;
      if (!i_req_write) begin
        case (kind)
          `CLINT_KIND_MSIP:     rd_val = xlen_t'(m_msip[hart]);
          `CLINT_KIND_MTIMECMP: rd_val = m_cmp[hart];
          `CLINT_KIND_MTIME:    rd_val = m_mtime;
          default:              rd_val = '0;
        endcase
      end else begin
        case (kind)
          `CLINT_KIND_MSIP:     if (i_req_byte_en[0]) m_msip[hart] = i_req_data[0];
          `CLINT_KIND_MTIMECMP: m_cmp[hart] = merge_bytes(m_cmp[hart], i_req_data, i_req_byte_en);
          `CLINT_KIND_MTIME:    next_mtime = merge_bytes(next_mtime, i_req_data, i_req_byte_en);
          default:              ;
        endcase
      end
      exp_tag_q.push_back(i_req_tag);
      exp_data_q.push_back(rd_val);
    end
    m_mtime = next_mtime;
  endtask

  // inputs move only on the rising edge, so the falling edge sees settled values
  always @(negedge i_clk) begin
    if (!i_reset_n) begin
      model_reset();
    end else begin
      check_outputs();
      check_response();
      update_model();
    end
  end

  resp_hold_blocks_req: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(o_resp_valid && !i_resp_ready && o_req_ready))
    else report_mismatch("o_req_ready", 64'd0, xlen_t'($sampled(o_req_ready)));

  accept_gives_resp: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_req_valid && o_req_ready) |=> o_resp_valid)
    else report_mismatch("o_resp_valid", 64'd1, xlen_t'($sampled(o_resp_valid)));

  // ----------------------------------------------------------------------------
  // drivers called just after a rising edge
  // ----------------------------------------------------------------------------

  task automatic drive_resp_ready();
    int rnd;
    @(posedge i_clk);
    rnd = $random(seed);
    case (resp_mode)
      0:       i_resp_ready <= 1'b1;
      1:       i_resp_ready <= rnd[0];
      default: i_resp_ready <= 1'b0;
    endcase
  endtask

  always drive_resp_ready();

  task automatic send_req(input logic write, input reg_off_t off, input xlen_t data,
                          input byte_en_t be);
    i_req_valid   <= 1'b1;
    i_req_write   <= write;
    i_req_off     <= off;
    i_req_tag     <= next_tag;
    i_req_data    <= data;
    i_req_byte_en <= be;
    next_tag = next_tag + 1'b1;
    @(negedge i_clk);
    while (!o_req_ready) @(negedge i_clk);
    @(posedge i_clk);               // accepted on this edge
    i_req_valid <= 1'b0;
  endtask

  task automatic write_reg(input reg_off_t off, input xlen_t data, input byte_en_t be);
    send_req(1'b1, off, data, be);
  endtask

  task automatic read_reg(input reg_off_t off);
    send_req(1'b0, off, '0, '0);
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge i_clk);
  endtask

  task automatic wait_drained();
    do @(negedge i_clk); while (exp_tag_q.size() != 0);
    @(posedge i_clk);
  endtask

  function automatic reg_off_t offset_at(input logic [3:0] idx);
    case (idx)
      4'd0, 4'd1, 4'd2, 4'd3:   return msip_off(idx);
      4'd4, 4'd5, 4'd6, 4'd7:   return mtimecmp_off(idx - 4);
      4'd8:  return `CLINT_MTIME_OFF;
      4'd9:  return 16'h0010;           // past the last msip
      4'd10: return 16'h0002;           // misaligned msip
      4'd11: return 16'h4020;           // past the last mtimecmp
      4'd12: return 16'h4004;           // misaligned mtimecmp
      4'd13: return 16'hbff0;
      4'd14: return 16'hbffc;
      default: return 16'h8000;
    endcase
  endfunction

  // ----------------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------------

  initial begin
    int    sel;
    xlen_t x_val;
    seed          = 32'h5b3f_4d2a;
    i_clk         = 1'b0;
    i_reset_n     = 1'b0;
    i_req_valid   = 1'b0;
    i_req_write   = 1'b0;
    i_req_off     = '0;
    i_req_tag     = '0;
    i_req_data    = '0;
    i_req_byte_en = '0;
    i_resp_ready  = 1'b1;
    resp_mode     = 0;
    cycle_count   = 0;
    next_tag      = '0;
    repeat (16) @(posedge i_clk);
    i_reset_n <= 1'b1;
    @(negedge i_clk);
    assert (!o_resp_valid) else report_mismatch("o_resp_valid", 64'd0, xlen_t'(o_resp_valid));
    assert (o_req_ready) else report_mismatch("o_req_ready", 64'd1, xlen_t'(o_req_ready));
    @(posedge i_clk);

    for (int h = 0; h < NUM_HARTS; h++) read_reg(mtimecmp_off(h));

    // msip set, read back, clear, and a write without byte 0
    resp_mode <= 1;
    for (int h = 0; h < NUM_HARTS; h++) begin
      write_reg(msip_off(h), 64'd1, 8'h01);
      read_reg(msip_off(h));
    end
    write_reg(msip_off(1), 64'd0, 8'hfe);
    for (int h = 0; h < NUM_HARTS; h++) begin
      write_reg(msip_off(h), 64'd0, 8'h01);
      read_reg(msip_off(h));
    end

    // mtimecmp byte merge
    write_reg(mtimecmp_off(2), 64'h0123_4567_89ab_cdef, 8'hff);
    write_reg(mtimecmp_off(2), 64'hfedc_ba98_7654_3210, 8'b1010_0101);
    read_reg(mtimecmp_off(2));

    // mtime load, reads at growing distance, one hart below and one crossing
    wait_drained();
    resp_mode <= 0;
    x_val = 64'h0000_0012_3456_7000;
    write_reg(`CLINT_MTIME_OFF, x_val, 8'hff);
    write_reg(mtimecmp_off(0), x_val - 64'd50, 8'hff);
    write_reg(mtimecmp_off(1), x_val + 64'd40, 8'hff);
    write_reg(mtimecmp_off(2), x_val + 64'd100000, 8'hff);
    write_reg(mtimecmp_off(3), x_val + 64'd200000, 8'hff);
    for (int k = 0; k < 6; k++) begin
      write_reg(`CLINT_MTIME_OFF, x_val, 8'hff);
      idle(k);
      read_reg(`CLINT_MTIME_OFF);
    end
    idle(40);
    read_reg(`CLINT_MTIME_OFF);
    write_reg(`CLINT_MTIME_OFF, 64'hffff_ffff_ffff_fffc, 8'hff);   // wrap
    repeat (4) read_reg(`CLINT_MTIME_OFF);

    // back-pressure holds the second request
    wait_drained();
    resp_mode <= 2;
    idle(2);
    read_reg(`CLINT_MTIME_OFF);
    fork
      read_reg(mtimecmp_off(2));
      begin
        repeat (6) begin
          @(negedge i_clk);
          assert (!o_req_ready) else report_mismatch("o_req_ready", 64'd0, xlen_t'(o_req_ready));
        end
        @(posedge i_clk);
        resp_mode <= 0;
      end
    join

    // unmapped reads and writes
    for (int i = 9; i < 16; i++) read_reg(offset_at(i[3:0]));
    for (int i = 9; i < 16; i++) write_reg(offset_at(i[3:0]), '1, 8'hff);
    for (int i = 0; i < 9; i++) read_reg(offset_at(i[3:0]));

    // random mix
    resp_mode <= 1;
    for (int n = 0; n < 40; n++) begin
      sel   = $random(seed);
      x_val = {$random(seed), $random(seed)};
      if (sel[4]) begin
        write_reg(offset_at(sel[3:0]), x_val, sel[15:8]);
      end else begin
        read_reg(offset_at(sel[3:0]));
      end
    end
    wait_drained();
    resp_mode <= 0;
    idle(4);

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+rtl
rtl/clint_pkg.sv
rtl/clint_req_decode.sv
rtl/clint_mtime.sv
rtl/clint_hart_irq.sv
rtl/clint_resp_mux.sv
rtl/clint.sv
sim/tb_clint.sv
